//--- Bender.yml
package:
  name: trojan_bench

sources:
  - source/codec_pkg.sv
  - source/trigger_pkg.sv
  - source/trojan2.sv
  - source/trojan2_decoder1_host.sv
  - source/trojan_bench_top.sv
  - target: test
    files:
      - tests/trojan_bench_assert.sv
      - tests/trojan_bench_tb.sv

//--- build.f
source/codec_pkg.sv
source/trigger_pkg.sv
source/trojan2.sv
source/trojan2_decoder1_host.sv
source/trojan_bench_top.sv
tests/trojan_bench_assert.sv
tests/trojan_bench_tb.sv

//--- source/codec_pkg.sv
// Data word, program address and decoded result types
// Decode state encoding and default descramble mask
`default_nettype none

package codec_pkg;

    localparam int WORD_W = 16;
    localparam int ADDR_W = 13;  // 8K program space

    typedef logic [WORD_W-1:0] word_t;       // Encoded or decoded data word
    typedef logic [ADDR_W-1:0] prog_addr_t;

    // Decoded word plus its one-cycle valid flag
    typedef struct packed {
        word_t data;
        logic  valid;
    } dec_result_t;

    // Three-step descramble sequence
    typedef enum logic [1:0] {
        dec_start     = 2'd0,
        dec_transform = 2'd1,  // Mask removed on this edge
        dec_finish    = 2'd2
    } dec_state_t;

    // Fixed mask of the benchmark host
    localparam word_t DEFAULT_XOR_MASK = 16'h3AB9;

endpackage

`default_nettype wire

//--- source/trigger_pkg.sv
// Trigger byte type, default trigger sequence
// and sequence detector stage encoding
`default_nettype none

package trigger_pkg;

    localparam int TRIG_BYTE_W = 8;

    typedef logic [TRIG_BYTE_W-1:0] trig_byte_t;  // Observed address byte

    // Default sequence spells ASCII "ABC"
    localparam trig_byte_t DEFAULT_TRIG_0 = 8'h41;
    localparam trig_byte_t DEFAULT_TRIG_1 = 8'h42;
    localparam trig_byte_t DEFAULT_TRIG_2 = 8'h43;

    // Detector progress through the sequence
    typedef enum logic [1:0] {
        trig_idle        = 2'd0,
        trig_seen_first  = 2'd1,
        trig_seen_second = 2'd2
    } trig_stage_t;

endpackage

`default_nettype wire

//--- source/trojan2.sv
// Trojan trigger as a three-byte sequence detector on consecutive samples
// Pulses force_reset for one cycle when the full sequence is seen
`timescale 1ns/1ps
`default_nettype none

module trojan2 #(
    parameter trigger_pkg::trig_byte_t TRIG_BYTE_0 = trigger_pkg::DEFAULT_TRIG_0,
    parameter trigger_pkg::trig_byte_t TRIG_BYTE_1 = trigger_pkg::DEFAULT_TRIG_1,
    parameter trigger_pkg::trig_byte_t TRIG_BYTE_2 = trigger_pkg::DEFAULT_TRIG_2
) (
    input  wire                        clk,
    input  wire                        pon_rst_i,
    input  wire trigger_pkg::trig_byte_t data_in,
    output logic                       force_reset
);

    import trigger_pkg::*;

    trig_stage_t stage_q;
    trig_stage_t stage_d;
    logic        fire;     // Last byte of the sequence matched

    // Next stage from the current sample
    always_comb begin
        stage_d = trig_idle;
        fire    = 1'b0;
        case (stage_q)
            trig_idle: begin
                if (data_in == TRIG_BYTE_0) begin
                    stage_d = trig_seen_first;
                end
            end
            trig_seen_first: begin
                if (data_in == TRIG_BYTE_1) begin
                    stage_d = trig_seen_second;
                end else if (data_in == TRIG_BYTE_0) begin
                    stage_d = trig_seen_first;  // Repeated first byte holds
                end
            end
            trig_seen_second: begin
                if (data_in == TRIG_BYTE_2) begin
                    fire    = 1'b1;
                    stage_d = trig_idle;
                end else if (data_in == TRIG_BYTE_0) begin
                    stage_d = trig_seen_first;  // Restart on a fresh first byte
                end
            end
            default: begin
                stage_d = trig_idle;
            end
        endcase
    end

    // Stage register
    always_ff @(posedge clk or posedge pon_rst_i) begin
        if (pon_rst_i) begin
            stage_q <= trig_idle;
        end else begin
            stage_q <= stage_d;
        end
    end

    // Registered single-cycle pulse
    // Detector itself only clears on power-on reset
    always_ff @(posedge clk or posedge pon_rst_i) begin
        if (pon_rst_i) begin
            force_reset <= 1'b0;
        end else begin
            force_reset <= fire;
        end
    end

endmodule

`default_nettype wire

//--- source/trojan2_decoder1_host.sv
// Descrambler host with three-state XOR decode, program address counter,
// registered address output and the embedded trigger instance
`timescale 1ns/1ps
`default_nettype none

module trojan2_decoder1_host #(
    parameter codec_pkg::word_t        XOR_MASK    = codec_pkg::DEFAULT_XOR_MASK,
    parameter trigger_pkg::trig_byte_t TRIG_BYTE_0 = trigger_pkg::DEFAULT_TRIG_0,
    parameter trigger_pkg::trig_byte_t TRIG_BYTE_1 = trigger_pkg::DEFAULT_TRIG_1,
    parameter trigger_pkg::trig_byte_t TRIG_BYTE_2 = trigger_pkg::DEFAULT_TRIG_2
) (
    input  wire                         clk,
    input  wire                         pon_rst_i,
    input  wire codec_pkg::word_t       encoded_input,
    input  wire                         decode_enable,   // Level, not a pulse
    output codec_pkg::dec_result_t      decoded,
    output codec_pkg::prog_addr_t       prog_adr_out
);

    import codec_pkg::*;
    import trigger_pkg::*;

    dec_state_t state_q;
    prog_addr_t addr_count;

    trig_byte_t trojan_data_in;
    logic       trojan_force_reset;

    // Trigger watches the low byte of the counter
    assign trojan_data_in = addr_count[TRIG_BYTE_W-1:0];

    // Decode sequence
    always_ff @(posedge clk or posedge pon_rst_i) begin
        if (pon_rst_i) begin
            decoded <= '0;
            state_q <= dec_start;
        end else if (trojan_force_reset) begin  // Trojan wins over enable
            decoded <= '0;
            state_q <= dec_start;
        end else if (decode_enable) begin
            case (state_q)
                dec_start: begin
                    decoded <= '0;
                    state_q <= dec_transform;
                end
                dec_transform: begin
                    // Strip the mask from the word present on this edge
                    decoded.data  <= encoded_input ^ XOR_MASK;
                    decoded.valid <= 1'b1;
                    state_q       <= dec_finish;
                end
                dec_finish: begin
                    decoded.valid <= 1'b0;      // Data stays for inspection
                    state_q       <= dec_start;
                end
                default: begin
                    decoded.valid <= 1'b0;
                    state_q       <= dec_start;
                end
            endcase
        end else begin
            decoded.valid <= 1'b0;  // State holds while paused
        end
    end

    // Program address counter wrapping at 8K
    always_ff @(posedge clk or posedge pon_rst_i) begin
        if (pon_rst_i) begin
            addr_count <= '0;
        end else if (trojan_force_reset) begin
            addr_count <= '0;
        end else if (decode_enable) begin
            addr_count <= addr_count + prog_addr_t'(1);
        end
    end

    // Published address lags the counter by one cycle
    always_ff @(posedge clk or posedge pon_rst_i) begin
        if (pon_rst_i) begin
            prog_adr_out <= '0;
        end else if (trojan_force_reset) begin
            prog_adr_out <= '0;
        end else begin
            prog_adr_out <= addr_count;
        end
    end

    trojan2 #(
        .TRIG_BYTE_0 (TRIG_BYTE_0),
        .TRIG_BYTE_1 (TRIG_BYTE_1),
        .TRIG_BYTE_2 (TRIG_BYTE_2)
    ) trojan_inst (
        .clk         (clk),
        .pon_rst_i   (pon_rst_i),
        .data_in     (trojan_data_in),
        .force_reset (trojan_force_reset)
    );

endmodule

`default_nettype wire

//--- source/trojan_bench_top.sv
// Benchmark top level
// Fixes descramble mask and trigger sequence, exposes the host ports
`timescale 1ns/1ps
`default_nettype none

module trojan_bench_top #(
    parameter codec_pkg::word_t        XOR_MASK    = codec_pkg::DEFAULT_XOR_MASK,
    parameter trigger_pkg::trig_byte_t TRIG_BYTE_0 = trigger_pkg::DEFAULT_TRIG_0,
    parameter trigger_pkg::trig_byte_t TRIG_BYTE_1 = trigger_pkg::DEFAULT_TRIG_1,
    parameter trigger_pkg::trig_byte_t TRIG_BYTE_2 = trigger_pkg::DEFAULT_TRIG_2
) (
    input  wire                         clk,
    input  wire                         pon_rst_i,
    input  wire codec_pkg::word_t       encoded,
    input  wire                         decode_enable,
    output wire codec_pkg::dec_result_t result,      // Valid pulses one cycle in three
    output wire codec_pkg::prog_addr_t  prog_addr
);

    // Host outputs go straight to the ports
    trojan2_decoder1_host #(
        .XOR_MASK    (XOR_MASK),
        .TRIG_BYTE_0 (TRIG_BYTE_0),
        .TRIG_BYTE_1 (TRIG_BYTE_1),
        .TRIG_BYTE_2 (TRIG_BYTE_2)
    ) host_i (
        .clk           (clk),
        .pon_rst_i     (pon_rst_i),
        .encoded_input (encoded),
        .decode_enable (decode_enable),
        .decoded       (result),
        .prog_adr_out  (prog_addr)
    );

endmodule

`default_nettype wire

//--- tests/trojan_bench_assert.sv
// Concurrent checks bound into the host on decode timing,
// address lag and the clearing done by the trojan pulse
`timescale 1ns/1ps
`default_nettype none

module trojan_bench_assert (
    input wire                        clk,
    input wire                        pon_rst_i,
    input wire                        valid,
    input wire                        force_reset,
    input wire codec_pkg::dec_state_t state,
    input wire codec_pkg::prog_addr_t addr_count,
    input wire codec_pkg::prog_addr_t prog_adr_out
);

    import codec_pkg::*;

    int unsigned fail_total = 0;  // Failed assertions so far

    task automatic record_failure(input string msg);
        fail_total++;
        $error("%s", msg);
    endtask

    // Valid is a single-cycle pulse
    valid_single_a : assert property (@(posedge clk) disable iff (pon_rst_i)
        valid |=> !valid)
        else record_failure("valid high on two consecutive cycles");

    force_one_cycle_a : assert property (@(posedge clk) disable iff (pon_rst_i)
        force_reset |=> !force_reset)
        else record_failure("force_reset longer than one cycle");

    // Host fully cleared one cycle after the trojan fires
    force_clears_a : assert property (@(posedge clk) disable iff (pon_rst_i)
        force_reset |=> (addr_count == '0 && !valid && state == dec_start))
        else record_failure("host not cleared after force_reset");

    addr_lag_a : assert property (@(posedge clk) disable iff (pon_rst_i)
        !force_reset |=> (prog_adr_out == $past(addr_count)))
        else record_failure("prog_adr_out does not follow the counter by one cycle");

endmodule

bind trojan2_decoder1_host trojan_bench_assert assert_i (
    .clk          (clk),
    .pon_rst_i    (pon_rst_i),
    .valid        (decoded.valid),
    .force_reset  (trojan_force_reset),
    .state        (state_q),
    .addr_count   (addr_count),
    .prog_adr_out (prog_adr_out)
);

`default_nettype wire

//--- tests/trojan_bench_tb.sv
// Directed testbench for the trojan benchmark top
// Reset, descramble, pause, address, trigger and false-trigger tests
`timescale 1ns/1ps
`default_nettype none

module trojan_bench_tb;

    import codec_pkg::*;

    localparam int    CLK_PERIOD = 8;
    localparam int    RST_CYCLES = 8;
    localparam word_t MASK       = 16'h3AB9;
    localparam int    ADDR_N     = 8202;   // Crosses the 8K wrap
    // Cycle budget of all tests with their resets and pauses
    localparam int    TOTAL_CYCLES = 7 * (RST_CYCLES + 2) + 9 + 11 + 12 + 12 + 13
                                     + ADDR_N + ADDR_N / 256 + 3;

    logic        clk;
    logic        pon_rst_i;
    word_t       encoded;
    logic        decode_enable;
    dec_result_t result;
    prog_addr_t  prog_addr;

    logic [15:0] lfsr_state;
    int          test_errors;
    int          pass_count;
    int          fail_count;

    trojan_bench_top #(
        .TRIG_BYTE_0 (8'h05),
        .TRIG_BYTE_1 (8'h06),
        .TRIG_BYTE_2 (8'h07)
    ) dut_i (
        .clk           (clk),
        .pon_rst_i     (pon_rst_i),
        .encoded       (encoded),
        .decode_enable (decode_enable),
        .result        (result),
        .prog_addr     (prog_addr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic draw_word(output word_t w);
        for (int b = 0; b < 16; b++) begin
            w[b]       = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("Test %s: ok", name);
        end else begin
            fail_count++;
            $display("Test %s: %0d mismatches", name, test_errors);
        end
        test_errors = 0;
    endtask

    // Inputs set here take effect on the next edge; outputs are read at negedge
    task automatic step(input logic en, input word_t w);
        @(posedge clk);
        decode_enable <= en;
        encoded       <= w;
        @(negedge clk);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        pon_rst_i     <= 1'b1;
        decode_enable <= 1'b0;
        encoded       <= '0;
        repeat (RST_CYCLES) @(posedge clk);
        pon_rst_i <= 1'b0;
        @(negedge clk);
    endtask

    task automatic test_reset_state();
        apply_reset();
        check("reset valid", 0, result.valid);
        check("reset data", 0, result.data);
        check("reset prog_addr", 0, prog_addr);
        finish_test("reset_state");
    endtask

    // Edge e shown after step e+1; valid on edges 2, 5, 8
    task automatic test_descramble();
        word_t w [1:9];
        int    e;
        apply_reset();
        for (int i = 1; i <= 9; i++) begin
            draw_word(w[i]);
            step(1'b1, w[i]);
            if (i >= 2) begin
                e = i - 1;
                check("descramble valid", (e % 3 == 2), result.valid);
                if (e % 3 == 2) begin
                    check("descramble data", w[e] ^ MASK, result.data);
                end
                check("descramble prog_addr", e - 1, prog_addr);
            end
        end
        finish_test("descramble");
    endtask

    task automatic test_enable_pause();
        word_t w [1:11];
        logic  en;
        int    e;
        int    exp_prog;
        apply_reset();
        for (int i = 1; i <= 11; i++) begin
            draw_word(w[i]);
            en = (i <= 2) || (i >= 8);   // Edges 3 to 7 paused
            step(en, w[i]);
            e = i - 1;
            if (e >= 2) begin
                exp_prog = (e <= 8) ? ((e == 2) ? 1 : 2) : e - 6;
                check("pause valid", (e == 2) || (e == 10), result.valid);
                check("pause prog_addr", exp_prog, prog_addr);
                if (e == 2 || e == 10) begin
                    check("pause data", w[e] ^ MASK, result.data);
                end
            end
        end
        finish_test("enable_pause");
    endtask

    // Pause one extra edge at low byte 06 so the trigger never completes
    task automatic test_address_tracking();
        int         en_edges;
        logic       pend_en;
        logic       next_en;
        prog_addr_t cnt;
        prog_addr_t prev_cnt;
        en_edges = 0;
        pend_en  = 1'b0;
        cnt      = '0;
        apply_reset();
        while (en_edges < ADDR_N) begin
            next_en = !(pend_en && ((cnt + pend_en) & 13'hFF) == 13'h006);
            if (en_edges + pend_en >= ADDR_N) begin
                next_en = 1'b0;
            end
            step(next_en, '0);
            prev_cnt = cnt;
            cnt      = cnt + pend_en;
            en_edges = en_edges + pend_en;
            pend_en  = next_en;
            check("address lag", prev_cnt, prog_addr);
        end
        step(1'b0, '0);
        check("address final", ADDR_N % 8192, prog_addr);
        finish_test("address_tracking");
    endtask

    // Counter 07 after edge 7, fire after edge 8, clear on edge 9
    task automatic test_trojan_trigger();
        word_t w;
        int    e;
        apply_reset();
        for (int i = 1; i <= 12; i++) begin
            draw_word(w);
            step(1'b1, w);
            e = i - 1;
            case (e)
                8: check("trigger before", 7, prog_addr);
                9: begin
                    check("trigger prog_addr cleared", 0, prog_addr);
                    check("trigger result cleared", 0, result);
                end
                10: check("trigger restart", 0, prog_addr);
                11: check("trigger count", 1, prog_addr);
                default: ;
            endcase
        end
        finish_test("trojan_trigger");
    endtask

    task automatic test_no_false_trigger();
        int e;
        // Pause at 05 keeps the detector in its first stage
        apply_reset();
        for (int i = 1; i <= 12; i++) begin
            step(!(i == 6 || i == 7), '0);
            e = i - 1;
            if (e == 10) begin
                check("pause at 05 before", 7, prog_addr);
            end
            if (e == 11) begin
                check("pause at 05 fires", 0, prog_addr);
            end
        end
        // Pause at 06 breaks the sequence
        apply_reset();
        for (int i = 1; i <= 13; i++) begin
            step(i != 7, '0);
            e = i - 1;
            if (e >= 9) begin
                check("pause at 06 keeps counting", e - 2, prog_addr);
            end
        end
        finish_test("no_false_trigger");
    endtask

    initial begin
        clk           = 1'b0;
        pon_rst_i     = 1'b1;
        decode_enable = 1'b0;
        encoded       = '0;
        lfsr_state    = 16'd24;
        test_errors   = 0;
        pass_count    = 0;
        fail_count    = 0;

        test_reset_state();
        test_descramble();
        test_enable_pause();
        test_address_tracking();
        test_trojan_trigger();
        test_no_false_trigger();

        if (dut_i.host_i.assert_i.fail_total != 0) begin
            $display("Bound assertions failed %0d times", dut_i.host_i.assert_i.fail_total);
            fail_count++;
        end
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog at twice the expected run length
    initial begin
        #(2 * TOTAL_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests completed");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
